/* Makefile */
# Verilator flow for the FIFO to AXI-Stream egress path

TOP = tb_fifo_stream

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module fifo_stream_top
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* rtl/fifo2axis.sv */
/*
 * fifo2axis streamer
 * drains the FIFO ahead of time and drives an AXI-Stream master with tlast every len words
 */
`timescale 1ns/1ps
`include "fifo2axis_settings.svh"

module fifo2axis
   import fifo2axis_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  en_i,
   input  logic [`FS_LEN_W-1:0]  len_i,
   fifo_rd_if.strm_mp            fifo,
   output logic                  axis_tvalid_o,
   output logic [`FS_DATA_W-1:0] axis_tdata_o,
   output logic                  axis_tlast_o,
   input  logic                  axis_tready_i,
   output hold_level_e           level_o
);

   logic                  rd_q;
   logic                  rd_room;
   logic                  saved_q;
   logic [`FS_DATA_W-1:0] saved_data_q;
   logic                  saved_last_q;
   logic [`FS_LEN_W-1:0]  word_cnt_q;
   logic [`FS_LEN_W-1:0]  len_m1;
   logic                  last_nxt;
   logic                  out_en;

   // room for another word
   // sink ready, or nothing saved and nothing in flight
   assign rd_room = axis_tready_i | ~(saved_q | rd_q);
   assign fifo.rd = en_i & ~fifo.empty & rd_room;

   // FIFO data is valid while rd_q is high
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_q <= 1'b0;
      end else begin
         rd_q <= fifo.rd;
      end
   end

   // len of 0 wraps to 255, so a frame of 256 words
   assign len_m1 = len_i - 1'b1;

   // starts at all ones so the first read becomes word 0
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         word_cnt_q <= '1;
      end else if (fifo.rd) begin
         if (word_cnt_q == len_m1) begin
            word_cnt_q <= '0;
         end else begin
            word_cnt_q <= word_cnt_q + 1'b1;
         end
      end
   end

   // counter already points at the arriving word
   assign last_nxt = (word_cnt_q == len_m1);

   assign out_en = ~axis_tvalid_o | axis_tready_i;

   // word arrived while the output was stalled
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         saved_q <= 1'b0;
      end else if (out_en) begin
         saved_q <= 1'b0;
      end else if (rd_q) begin
         saved_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_q) begin
         saved_data_q <= fifo.rdata;
         saved_last_q <= last_nxt;
      end
   end

   // output stage, saved word goes first
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         axis_tvalid_o <= 1'b0;
         axis_tlast_o  <= 1'b0;
      end else if (out_en) begin
         axis_tvalid_o <= saved_q | rd_q;
         axis_tlast_o  <= saved_q ? saved_last_q : last_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_en) begin
         axis_tdata_o <= saved_q ? saved_data_q : fifo.rdata;
      end
   end

   always_comb begin
      if (saved_q && axis_tvalid_o) begin
         level_o = HOLD_TWO;
      end else if (saved_q || axis_tvalid_o) begin
         level_o = HOLD_ONE;
      end else begin
         level_o = HOLD_NONE;
      end
   end

endmodule

/* rtl/fifo2axis_pkg.sv */
/*
 * fifo2axis package
 * register map and streamer holding level types
 */
`include "fifo2axis_settings.svh"

package fifo2axis_pkg;

   // register map
   typedef enum logic [`FS_REG_AW-1:0] {
      REG_CTRL   = 2'd0,
      REG_LEN    = 2'd1,
      REG_FRAMES = 2'd2,
      REG_STATUS = 2'd3
   } reg_addr_e;

   // words held inside the streamer
   typedef enum logic [1:0] {
      HOLD_NONE = 2'd0,
      HOLD_ONE  = 2'd1,
      HOLD_TWO  = 2'd2
   } hold_level_e;

endpackage

/* rtl/fifo2axis_settings.svh */
/*
 * fifo2axis settings
 * widths and depth shared by the FIFO egress path
 */
`ifndef FIFO2AXIS_SETTINGS_SVH
`define FIFO2AXIS_SETTINGS_SVH

// stream word width
`define FS_DATA_W 16

// frame length and word counter width
`define FS_LEN_W 8

// FIFO address width, depth is 2**FS_FIFO_AW
`define FS_FIFO_AW 4

// register address width
`define FS_REG_AW 2

`endif

/* rtl/fifo_rd_if.sv */
/*
 * FIFO read side bundle
 * strobe, registered data, empty flag and fill count
 */
`timescale 1ns/1ps
`include "fifo2axis_settings.svh"

interface fifo_rd_if;

   logic                   rd;
   logic [`FS_DATA_W-1:0]  rdata;
   logic                   empty;
   logic [`FS_FIFO_AW:0]   count;

   modport fifo_mp (input rd, output rdata, output empty, output count);
   modport strm_mp (output rd, input rdata, input empty);
   // status readback only
   modport mon_mp  (input count);

endinterface

/* rtl/fifo_stream_top.sv */
/*
 * fifo_stream_top
 * FIFO, AXI-Stream streamer and control registers
 */
`timescale 1ns/1ps
`include "fifo2axis_settings.svh"

module fifo_stream_top
   import fifo2axis_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  push_i,
   input  logic [`FS_DATA_W-1:0] push_data_i,
   output logic                  full_o,
   input  logic                  reg_wr_i,
   input  logic [`FS_REG_AW-1:0] reg_addr_i,
   input  logic [15:0]           reg_wdata_i,
   output logic [15:0]           reg_rdata_o,
   output logic                  axis_tvalid_o,
   output logic [`FS_DATA_W-1:0] axis_tdata_o,
   output logic                  axis_tlast_o,
   input  logic                  axis_tready_i
);

   logic                 en;
   logic [`FS_LEN_W-1:0] len;
   hold_level_e          level;

   fifo_rd_if fifo_rd ();

   sync_fifo fifo_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (push_i),
      .push_data_i (push_data_i),
      .full_o      (full_o),
      .rd          (fifo_rd.fifo_mp)
   );

   fifo2axis strm_i (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .en_i          (en),
      .len_i         (len),
      .fifo          (fifo_rd.strm_mp),
      .axis_tvalid_o (axis_tvalid_o),
      .axis_tdata_o  (axis_tdata_o),
      .axis_tlast_o  (axis_tlast_o),
      .axis_tready_i (axis_tready_i),
      .level_o       (level)
   );

   stream_regs regs_i (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .reg_wr_i      (reg_wr_i),
      .reg_addr_i    (reg_addr_e'(reg_addr_i)),
      .reg_wdata_i   (reg_wdata_i),
      .reg_rdata_o   (reg_rdata_o),
      .en_o          (en),
      .len_o         (len),
      .level_i       (level),
      .axis_tvalid_i (axis_tvalid_o),
      .axis_tready_i (axis_tready_i),
      .axis_tlast_i  (axis_tlast_o),
      .mon           (fifo_rd.mon_mp)
   );

endmodule

/* rtl/stream_regs.sv */
/*
 * stream_regs
 * enable and frame length control, frame counter and status readback
 */
`timescale 1ns/1ps
`include "fifo2axis_settings.svh"

module stream_regs
   import fifo2axis_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 reg_wr_i,
   input  reg_addr_e            reg_addr_i,
   input  logic [15:0]          reg_wdata_i,
   output logic [15:0]          reg_rdata_o,
   output logic                 en_o,
   output logic [`FS_LEN_W-1:0] len_o,
   input  hold_level_e          level_i,
   input  logic                 axis_tvalid_i,
   input  logic                 axis_tready_i,
   input  logic                 axis_tlast_i,
   fifo_rd_if.mon_mp            mon
);

   logic [15:0] frames_q;
   logic [15:0] status;
   logic        frame_done;

   // len only changes while disabled
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         en_o  <= 1'b0;
         len_o <= `FS_LEN_W'd4;
      end else if (reg_wr_i) begin
         case (reg_addr_i)
            REG_CTRL: en_o  <= reg_wdata_i[0];
            REG_LEN:  len_o <= reg_wdata_i[`FS_LEN_W-1:0];
            default:  ;
         endcase
      end
   end

   // a frame ends on the tlast transfer
   assign frame_done = axis_tvalid_i & axis_tready_i & axis_tlast_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         frames_q <= '0;
      end else if (frame_done) begin
         frames_q <= frames_q + 1'b1;
      end
   end

   // level in 1:0, fill count from bit 4 up
   always_comb begin
      status = '0;
      status[1:0] = level_i;
      status[4 +: `FS_FIFO_AW+1] = mon.count;
   end

   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         REG_CTRL:   reg_rdata_o[0] = en_o;
         REG_LEN:    reg_rdata_o[`FS_LEN_W-1:0] = len_o;
         REG_FRAMES: reg_rdata_o = frames_q;
         REG_STATUS: reg_rdata_o = status;
         default:    reg_rdata_o = '0;
      endcase
   end

endmodule

/* rtl/sync_fifo.sv */
/*
 * sync_fifo
 * single clock FIFO with registered read data and fill count
 */
`timescale 1ns/1ps
`include "fifo2axis_settings.svh"

module sync_fifo (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  push_i,
   input  logic [`FS_DATA_W-1:0] push_data_i,
   output logic                  full_o,
   fifo_rd_if.fifo_mp            rd
);

   localparam logic [`FS_FIFO_AW:0] DEPTH = 1 << `FS_FIFO_AW;

   logic [`FS_DATA_W-1:0]  mem [0:DEPTH-1];
   logic [`FS_FIFO_AW-1:0] wr_ptr;
   logic [`FS_FIFO_AW-1:0] rd_ptr;
   logic [`FS_FIFO_AW:0]   count;
   logic [`FS_DATA_W-1:0]  rdata_q;
   logic                   do_push;
   logic                   do_read;

   // drop pushes when full
   assign do_push = push_i & ~full_o;
   assign do_read = rd.rd & ~rd.empty;

   assign full_o   = (count == DEPTH);
   assign rd.empty = (count == '0);
   assign rd.count = count;
   assign rd.rdata = rdata_q;

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // read data shows up the cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (do_read) begin
         rdata_q <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // push and read together leave count alone
         case ({do_push, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* sim.f */
+incdir+rtl
rtl/fifo2axis_pkg.sv
rtl/fifo_rd_if.sv
rtl/sync_fifo.sv
rtl/fifo2axis.sv
rtl/stream_regs.sv
rtl/fifo_stream_top.sv
verification/tb_fifo_stream.sv

/* verification/tb_fifo_stream.sv */
/*
 * testbench for the FIFO to AXI-Stream egress path
 * random pushes, tready and register traffic checked against a queue model
 */
`timescale 1ns/1ps
`include "fifo2axis_settings.svh"

module tb_fifo_stream
   import fifo2axis_pkg::*;
;

   logic                  clk_i;
   logic                  reset_i;
   logic                  push_i;
   logic [`FS_DATA_W-1:0] push_data_i;
   logic                  full_o;
   logic                  reg_wr_i;
   logic [`FS_REG_AW-1:0] reg_addr_i;
   logic [15:0]           reg_wdata_i;
   logic [15:0]           reg_rdata_o;
   logic                  axis_tvalid_o;
   logic [`FS_DATA_W-1:0] axis_tdata_o;
   logic                  axis_tlast_o;
   logic                  axis_tready_i;

   // model state
   logic [`FS_DATA_W-1:0] model_q [$];
   int                    word_idx;
   int                    eff_len;
   logic [15:0]           frames;
   logic [7:0]            seq;
   int                    errors;
   int                    transfers;
   string                 test_name;
   logic                  timed_out;

   // output seen stalled on the last edge
   logic                  hold_valid;
   logic [`FS_DATA_W-1:0] hold_data;
   logic                  hold_last;
   logic                  expect_idle;

   fifo_stream_top dut_i (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .push_i        (push_i),
      .push_data_i   (push_data_i),
      .full_o        (full_o),
      .reg_wr_i      (reg_wr_i),
      .reg_addr_i    (reg_addr_i),
      .reg_wdata_i   (reg_wdata_i),
      .reg_rdata_o   (reg_rdata_o),
      .axis_tvalid_o (axis_tvalid_o),
      .axis_tdata_o  (axis_tdata_o),
      .axis_tlast_o  (axis_tlast_o),
      .axis_tready_i (axis_tready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic show_mismatch(input string what, input logic [15:0] expected,
                                input logic [15:0] actual);
      errors++;
      $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
   endtask

   task automatic end_run();
      $display("transfers %0d, errors %0d", transfers, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   endtask

   // word leaves on the coming rising edge
   task automatic check_transfer();
      logic [`FS_DATA_W-1:0] exp_data;
      logic                  exp_last;
      if (model_q.size() == 0) begin
         errors++;
         $display("%s: word %h was sent but nothing was pushed for it", test_name,
                  axis_tdata_o);
      end else begin
         exp_data = model_q.pop_front();
         exp_last = (word_idx == eff_len - 1);
         transfers++;
         if (axis_tdata_o !== exp_data) show_mismatch("tdata", exp_data, axis_tdata_o);
         if (axis_tlast_o !== exp_last) begin
            show_mismatch("tlast", {15'd0, exp_last}, {15'd0, axis_tlast_o});
         end
         if (exp_last) begin
            word_idx = 0;
            frames = frames + 16'd1;
         end else begin
            word_idx++;
         end
      end
   endtask

   // one clock cycle, entered and left just after a falling edge
   task automatic tick(input bit push_en, input bit ready);
      logic [`FS_DATA_W-1:0] word;
      word = {seq, 8'($urandom)};
      if (hold_valid) begin
         if (axis_tvalid_o !== 1'b1) begin
            show_mismatch("stall tvalid", 16'd1, {15'd0, axis_tvalid_o});
         end
         if (axis_tdata_o !== hold_data) show_mismatch("stall tdata", hold_data, axis_tdata_o);
         if (axis_tlast_o !== hold_last) begin
            show_mismatch("stall tlast", {15'd0, hold_last}, {15'd0, axis_tlast_o});
         end
      end
      if (expect_idle && axis_tvalid_o) begin
         show_mismatch("tvalid while disabled", 16'd0, 16'd1);
      end
      push_i = push_en;
      push_data_i = word;
      // pushes into a full FIFO are dropped
      if (push_en && !full_o) begin
         model_q.push_back(word);
         seq = seq + 8'd1;
      end
      axis_tready_i = ready;
      if (axis_tvalid_o && ready) check_transfer();
      hold_valid = axis_tvalid_o && !ready;
      hold_data = axis_tdata_o;
      hold_last = axis_tlast_o;
      @(negedge clk_i);
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
      reg_wr_i = 1'b1;
      reg_addr_i = addr;
      reg_wdata_i = data;
      tick(1'b0, ($urandom % 4) != 0);
      reg_wr_i = 1'b0;
   endtask

   task automatic check_reg(input string what, input logic [1:0] addr,
                            input logic [15:0] expected);
      reg_addr_i = addr;
      #1;
      if (reg_rdata_o !== expected) show_mismatch(what, expected, reg_rdata_o);
   endtask

   // run until the model queue is empty and the output is idle
   task automatic drain(input int limit);
      int cycles;
      cycles = 0;
      while (!timed_out && (model_q.size() != 0 || axis_tvalid_o)) begin
         if (cycles == limit) begin
            errors++;
            timed_out = 1'b1;
            $display("%s: stream stalled, %0d words never came out", test_name,
                     model_q.size());
         end else begin
            tick(1'b0, ($urandom % 4) != 0);
            cycles++;
         end
      end
   endtask

   task automatic apply_reset();
      reset_i = 1'b1;
      push_i = 1'b0;
      reg_wr_i = 1'b0;
      axis_tready_i = 1'b0;
      repeat (3) @(negedge clk_i);
      reset_i = 1'b0;
      model_q.delete();
      word_idx = 0;
      frames = 16'd0;
      hold_valid = 1'b0;
      expect_idle = 1'b0;
   endtask

   task automatic run_length(input logic [7:0] len, input string name);
      int i;
      test_name = name;
      // word counter restarts only on reset
      apply_reset();
      eff_len = (len == 8'd0) ? 256 : int'(len);
      write_reg(REG_LEN, {8'd0, len});
      check_reg("len readback", REG_LEN, {8'd0, len});
      check_reg("ctrl after reset", REG_CTRL, 16'd0);

      // fill past full while disabled
      expect_idle = 1'b1;
      for (i = 0; i < 20; i++) begin
         tick(1'b1, ($urandom % 2) != 0);
      end
      if (full_o !== 1'b1) show_mismatch("full_o after overflow", 16'd1, {15'd0, full_o});

      expect_idle = 1'b0;
      write_reg(REG_CTRL, 16'd1);
      check_reg("ctrl enabled", REG_CTRL, 16'd1);
      for (i = 0; i < 300; i++) begin
         tick(!full_o && (($urandom % 3) != 0), ($urandom % 4) != 0);
      end
      drain(2000);
      if (timed_out) return;

      // disabled after a drain, pending words must wait
      write_reg(REG_CTRL, 16'd0);
      check_reg("ctrl disabled", REG_CTRL, 16'd0);
      expect_idle = 1'b1;
      for (i = 0; i < 12; i++) begin
         tick(!full_o && (($urandom % 2) != 0), ($urandom % 2) != 0);
      end
      expect_idle = 1'b0;
      write_reg(REG_CTRL, 16'd1);
      drain(2000);
      if (timed_out) return;

      check_reg("frame count", REG_FRAMES, frames);
      check_reg("idle status", REG_STATUS, {7'd0, 5'd0, 2'd0, HOLD_NONE});
   endtask

   initial begin
      void'($urandom(32'h2c3e));
      reset_i = 1'b1;
      push_i = 1'b0;
      push_data_i = '0;
      reg_wr_i = 1'b0;
      reg_addr_i = '0;
      reg_wdata_i = 16'd0;
      axis_tready_i = 1'b0;
      errors = 0;
      transfers = 0;
      timed_out = 1'b0;
      seq = 8'd0;
      word_idx = 0;
      eff_len = 4;
      frames = 16'd0;
      hold_valid = 1'b0;
      hold_data = '0;
      hold_last = 1'b0;
      expect_idle = 1'b0;
      test_name = "init";

      run_length(8'd4, "len4");
      if (!timed_out) begin
         run_length(8'd7, "len7");
      end
      if (!timed_out) begin
         run_length(8'd1, "len1");
      end
      end_run();
   end

endmodule
